/* sources.f */
+incdir+tb
verilog/xt_pkg.sv
verilog/xt_decode.sv
verilog/xt_sequencer.sv
verilog/xt_uop_emit.sv
verilog/xt_translate.sv
tb/xt_translate_tb.sv

/* Bender.yml */
package:
  name: xt_translate

sources:
  - verilog/xt_pkg.sv
  - verilog/xt_decode.sv
  - verilog/xt_sequencer.sv
  - verilog/xt_uop_emit.sv
  - verilog/xt_translate.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/xt_translate_tb.sv

/* tb/xt_tb_vectors.svh */
`ifndef XT_TB_VECTORS_SVH
`define XT_TB_VECTORS_SVH

// Each row holds name, instr, pc (0 picks a random pc), flush step, stall step,
// stall cycles, micro-op count and the expected out_instr per step
// Step 7 means no flush or stall

typedef struct packed {
    logic [63:0]      name;
    logic [23:0]      instr;
    logic [23:0]      pc;
    logic [2:0]       flush_at;
    logic [2:0]       stall_at;
    logic [3:0]       stall_len;
    logic [2:0]       n;
    logic [0:5][23:0] exp;
} vec_t;

localparam logic [2:0]  NONE = 3'd7;
localparam logic [23:0] ZW   = 24'h000000;

localparam int NUM_VECTORS = 18;

localparam vec_t VECTORS [NUM_VECTORS] = '{
    '{"pass_0", 24'h012345, 24'h000100, NONE, NONE, 4'd0, 3'd1,
      '{24'h012345, ZW, ZW, ZW, ZW, ZW}},
    '{"pass_3", 24'h3ABCDE, 24'h000104, NONE, NONE, 4'd0, 3'd1,
      '{24'h3ABCDE, ZW, ZW, ZW, ZW, ZW}},
    '{"pass_f", 24'hF0FFEE, 24'h000108, NONE, NONE, 4'd0, 3'd1,
      '{24'hF0FFEE, ZW, ZW, ZW, ZW, ZW}},
    '{"pass_9", 24'h915A5A, 24'h00010C, NONE, NONE, 4'd0, 3'd1,
      '{24'h915A5A, ZW, ZW, ZW, ZW, ZW}},
    '{"undef_8", 24'h81FFFF, 24'h000110, NONE, NONE, 4'd0, 3'd1,
      '{ZW, ZW, ZW, ZW, ZW, ZW}},
    '{"undef_c", 24'hC21234, 24'h000114, NONE, NONE, 4'd0, 3'd1,
      '{ZW, ZW, ZW, ZW, ZW, ZW}},
    '{"jccui", 24'h610ABC, 24'h000118, NONE, NONE, 4'd0, 3'd1,
      '{24'h610ABC, ZW, ZW, ZW, ZW, ZW}},
    '{"btp", 24'h60BEEF, 24'h00011C, NONE, NONE, 4'd0, 3'd1,
      '{ZW, ZW, ZW, ZW, ZW, ZW}},
    '{"setssp", 24'h904FFF, 24'h000120, NONE, NONE, 4'd0, 3'd1,
      '{24'hE69000, ZW, ZW, ZW, ZW, ZW}},
    // Call and return sequences
    '{"jsr", 24'h651234, ZW, NONE, NONE, 4'd0, 3'd4,
      '{24'hE18002, 24'hE39000, 24'hE47000, 24'h610234, ZW, ZW}},
    '{"bsr_reg", 24'h66A5C3, ZW, NONE, NONE, 4'd0, 3'd4,
      '{24'hE18002, 24'hE39000, 24'hE47000, 24'h62A000, ZW, ZW}},
    '{"bsr_off", 24'h670F0F, ZW, NONE, NONE, 4'd0, 3'd4,
      '{24'hE18002, 24'hE39000, 24'hE47000, 24'h640F0F, ZW, ZW}},
    '{"ret", 24'h681111, ZW, NONE, NONE, 4'd0, 3'd3,
      '{24'hE08002, 24'hE26FFE, 24'hE54001, ZW, ZW, ZW}},
    // Single-register push and pop
    '{"push", 24'h70B400, ZW, NONE, NONE, 4'd0, 3'd6,
      '{24'hE7BFFF, ZW, ZW, ZW, ZW, 24'hE9B400}},
    '{"pop", 24'h725C00, ZW, NONE, NONE, 4'd0, 3'd6,
      '{24'hE7C001, ZW, ZW, ZW, ZW, 24'hE85FFF}},
    '{"push_stl", 24'h704C00, ZW, NONE, 3'd2, 4'd4, 3'd6,
      '{24'hE77FFF, ZW, ZW, ZW, ZW, 24'hE94C00}},
    // Flush in the middle of a call, then a clean one
    '{"jsr_fl", 24'h650777, ZW, 3'd2, NONE, 4'd0, 3'd4,
      '{24'hE18002, 24'hE39000, 24'hE47000, 24'h610777, ZW, ZW}},
    '{"jsr_aft", 24'h650FED, ZW, NONE, NONE, 4'd0, 3'd4,
      '{24'hE18002, 24'hE39000, 24'hE47000, 24'h610FED, ZW, ZW}}
};

`endif

/* tb/xt_translate_tb.sv */
`default_nettype none

module xt_translate_tb;

    `include "xt_tb_vectors.svh"

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int SEED         = 34;

    logic        iw_clk;
    logic        iw_rst;
    logic [23:0] pc;
    logic [23:0] instr;
    logic        flush;
    logic        stall;
    logic [23:0] out_pc;
    logic [23:0] out_instr;
    logic        busy;
    logic        seq_start;

    int errors;
    int tests;
    int failed_tests;
    int cycles;
    int cycle_limit;

    xt_translate i_dut (
        .iw_clk    (iw_clk),
        .iw_rst    (iw_rst),
        .pc        (pc),
        .instr     (instr),
        .flush     (flush),
        .stall     (stall),
        .out_pc    (out_pc),
        .out_instr (out_instr),
        .busy      (busy),
        .seq_start (seq_start)
    );

    initial begin
        iw_clk = 1'b0;
        forever #(CLK_PERIOD / 2) iw_clk = ~iw_clk;
    end

    // Sample point one unit after the rising edge
    task automatic next_sample();
        @(posedge iw_clk);
        #1;
    endtask

    task automatic report_mismatch(input string name, input logic [23:0] expected,
                                   input logic [23:0] actual);
        $display("Mismatch at %0t: %s expected %06h, got %06h", $time, name, expected, actual);
        errors++;
    endtask

    task automatic finish_test(input logic [63:0] name, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("test %0d %0s: pass", tests, name);
        end else begin
            failed_tests++;
            $display("test %0d %0s: fail, %0d errors", tests, name, errors - errs_before);
        end
    endtask

    task automatic apply_vector(input vec_t v);
        logic [23:0] use_pc;
        logic        exp_busy;
        int          errs_before;
        int          i;
        bit          done;
        errs_before = errors;
        use_pc = (v.pc == '0) ? 24'($urandom) : v.pc;
        #1;
        instr = v.instr;
        pc    = use_pc;
        flush = 1'b0;
        stall = 1'b0;
        #1;
        if (seq_start !== (v.n > 3'd1)) report_mismatch("seq_start", v.n > 3'd1, seq_start);
        done = 1'b0;
        for (i = 0; i < v.n && !done; i++) begin
            if (i > 0) begin
                #1;
                if (i == v.flush_at) flush = 1'b1;
                if (i == v.stall_at) begin
                    stall = 1'b1;
                    repeat (v.stall_len) begin
                        next_sample();
                        if (out_instr !== v.exp[i-1]) begin
                            report_mismatch("out_instr", v.exp[i-1], out_instr);
                        end
                        if (out_pc !== use_pc) report_mismatch("out_pc", use_pc, out_pc);
                        if (busy !== 1'b1) report_mismatch("busy", 1'b1, busy);
                        #1;
                    end
                    stall = 1'b0;
                end
            end
            next_sample();
            if (flush) begin
                if (out_instr !== '0) report_mismatch("out_instr", '0, out_instr);
                if (out_pc !== '0) report_mismatch("out_pc", '0, out_pc);
                if (busy !== 1'b0) report_mismatch("busy", 1'b0, busy);
                done = 1'b1;
            end else begin
                exp_busy = (i < v.n - 1);
                if (out_instr !== v.exp[i]) report_mismatch("out_instr", v.exp[i], out_instr);
                if (out_pc !== use_pc) report_mismatch("out_pc", use_pc, out_pc);
                if (busy !== exp_busy) report_mismatch("busy", exp_busy, busy);
            end
        end
        while (busy !== 1'b0) next_sample();
        finish_test(v.name, errs_before);
    endtask

    // Watchdog sized from the table
    initial begin
        cycles = 0;
        cycle_limit = RESET_CYCLES;
        for (int k = 0; k < NUM_VECTORS; k++) begin
            cycle_limit += VECTORS[k].n;
        end
        cycle_limit = 2 * cycle_limit;
        while (cycles <= cycle_limit) begin
            @(posedge iw_clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, busy never fell", cycles);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        int errs_before;
        iw_rst = 1'b1;
        instr  = '0;
        pc     = '0;
        flush  = 1'b0;
        stall  = 1'b0;
        errors = 0;
        tests  = 0;
        failed_tests = 0;
        void'($urandom(SEED));

        repeat (RESET_CYCLES) next_sample();
        #1;
        iw_rst = 1'b0;
        next_sample();
        errs_before = errors;
        if (busy !== 1'b0) report_mismatch("busy", 1'b0, busy);
        if (seq_start !== 1'b0) report_mismatch("seq_start", 1'b0, seq_start);
        if (out_instr !== '0) report_mismatch("out_instr", '0, out_instr);
        if (out_pc !== '0) report_mismatch("out_pc", '0, out_pc);
        finish_test("reset", errs_before);

        for (int k = 0; k < NUM_VECTORS; k++) begin
            apply_vector(VECTORS[k]);
        end

        // Leave a NOP on the input so nothing restarts
        #1;
        instr = '0;
        pc    = '0;
        flush = 1'b0;
        next_sample();

        $display("tests %0d, failed tests %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/xt_translate.sv */
`default_nettype none

module xt_translate #(
    parameter int MAX_STEPS = 6
) (
    input  wire                   iw_clk,
    input  wire                   iw_rst,
    input  wire xt_pkg::xt_addr_t pc,
    input  wire xt_pkg::xt_word_t instr,
    input  wire                   flush,
    input  wire                   stall,
    output xt_pkg::xt_addr_t      out_pc,
    output xt_pkg::xt_word_t      out_instr,
    output logic                  busy,
    output logic                  seq_start
);
    import xt_pkg::*;

    xt_dec_t   dec;
    xt_state_e state;
    xt_step_t  step;
    xt_dec_t   held_dec;
    xt_addr_t  held_pc;

    xt_decode i_decode (
        .instr (instr),
        .dec   (dec)
    );

    xt_sequencer #(
        .MAX_STEPS (MAX_STEPS)
    ) i_sequencer (
        .iw_clk    (iw_clk),
        .iw_rst    (iw_rst),
        .flush     (flush),
        .stall     (stall),
        .dec       (dec),
        .pc        (pc),
        .state     (state),
        .step      (step),
        .held_dec  (held_dec),
        .held_pc   (held_pc),
        .seq_start (seq_start),
        .busy      (busy)
    );

    xt_uop_emit #(
        .MAX_STEPS (MAX_STEPS)
    ) i_uop_emit (
        .iw_clk    (iw_clk),
        .iw_rst    (iw_rst),
        .flush     (flush),
        .stall     (stall),
        .state     (state),
        .dec       (dec),
        .step      (step),
        .held_dec  (held_dec),
        .pc        (pc),
        .held_pc   (held_pc),
        .out_pc    (out_pc),
        .out_instr (out_instr)
    );

endmodule

`default_nettype wire

/* verilog/xt_uop_emit.sv */
`default_nettype none

module xt_uop_emit #(
    parameter int MAX_STEPS = 6
) (
    input  wire                    iw_clk,
    input  wire                    iw_rst,
    input  wire                    flush,
    input  wire                    stall,
    input  var  xt_pkg::xt_state_e state,
    input  wire xt_pkg::xt_dec_t   dec,
    input  wire xt_pkg::xt_step_t  step,
    input  wire xt_pkg::xt_dec_t   held_dec,
    input  wire xt_pkg::xt_addr_t  pc,
    input  wire xt_pkg::xt_addr_t  held_pc,
    output xt_pkg::xt_addr_t       out_pc,
    output xt_pkg::xt_word_t       out_instr
);
    import xt_pkg::*;

    localparam int STEP_W = $clog2(MAX_STEPS);

    xt_dec_t           cur_dec;
    xt_addr_t          cur_pc;
    logic [STEP_W-1:0] cur_step;
    xt_word_t          uop;

    function automatic xt_word_t compose(input xt_dec_t di, input logic [STEP_W-1:0] s);
        xt_payload_t p;
        logic [1:0]  a;
        logic [3:0]  c;
        logic [1:0]  d;
        logic [3:0]  r;
        logic [11:0] imm12;
        xt_word_t    w;
        p     = di.payload;
        a     = p[15:14];
        c     = p[13:10];
        d     = p[11:10];
        r     = p[15:12];
        imm12 = p[11:0];
        w     = '0;
        case (di.kind)
            PASS:        w = {di.opc, p};
            REWRITE_SSP: w = {OPC_SRMOVAUR, SR_SSP, a, 12'd0};
            MACRO: begin
                case (di.macro)
                    JSR, BSR_REG, BSR_OFF: begin
                        // Save the link register on the stack, then branch
                        if (s == STEP_W'(0)) begin
                            w = {OPC_SRSUBSI, SR_SSP, 14'd2};
                        end else if (s == STEP_W'(1)) begin
                            w = {OPC_SRSTSO, SR_SSP, SR_LR, 12'd0};
                        end else if (s == STEP_W'(2)) begin
                            w = {OPC_SRMOVUR, SR_LR, SR_PC, 12'd0};
                        end else if (di.macro == JSR) begin
                            w = {OPC_JCCUI, 4'd0, imm12};
                        end else if (di.macro == BSR_REG) begin
                            w = {OPC_BCCSR, r, 4'd0, 8'd0};
                        end else begin
                            w = {OPC_BALSO, p};
                        end
                    end
                    RET: begin
                        if (s == STEP_W'(0)) begin
                            w = {OPC_SRADDSI, SR_SSP, 14'd2};
                        end else if (s == STEP_W'(1)) begin
                            w = {OPC_SRLDSO, SR_LR, SR_SSP, 12'hFFE};
                        end else begin
                            w = {OPC_SRJCCSO, SR_LR, 4'd0, 10'd1};
                        end
                    end
                    PUSH: begin
                        if (s == STEP_W'(0)) begin
                            w = {OPC_CINCI, a, 14'h3FFF};
                        end else if (s == STEP_W'(5)) begin
                            w = {OPC_STCSO, a, c, 10'd0};
                        end else begin
                            w = {OPC_NOP, 16'd0};
                        end
                    end
                    POP: begin
                        if (s == STEP_W'(0)) begin
                            w = {OPC_CINCI, d, 14'd1};
                        end else if (s == STEP_W'(5)) begin
                            w = {OPC_LDCSO, r, d, 10'h3FF};
                        end else begin
                            w = {OPC_NOP, 16'd0};
                        end
                    end
                    default: w = '0;
                endcase
            end
            // Branch-target markers and undefined opclasses
            default:     w = '0;
        endcase
        return w;
    endfunction

    // Live decode starts a sequence, held copy carries it on
    assign cur_dec  = (state == BUSY) ? held_dec : dec;
    assign cur_pc   = (state == BUSY) ? held_pc : pc;
    assign cur_step = (state == BUSY) ? STEP_W'(step) : '0;
    assign uop      = compose(cur_dec, cur_step);

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            out_pc    <= '0;
            out_instr <= '0;
        end else if (flush) begin
            out_pc    <= '0;
            out_instr <= '0;
        end else if (!stall) begin
            out_pc    <= cur_pc;
            out_instr <= uop;
        end
    end

    a_out_held: assert property (@(posedge iw_clk) disable iff (iw_rst)
        stall && !flush |=> $stable(out_instr) && $stable(out_pc));

endmodule

`default_nettype wire

/* verilog/xt_sequencer.sv */
`default_nettype none

module xt_sequencer #(
    parameter int MAX_STEPS = 6
) (
    input  wire                    iw_clk,
    input  wire                    iw_rst,
    input  wire                    flush,
    input  wire                    stall,
    input  wire xt_pkg::xt_dec_t   dec,
    input  wire xt_pkg::xt_addr_t  pc,
    output xt_pkg::xt_state_e      state,
    output xt_pkg::xt_step_t       step,
    output xt_pkg::xt_dec_t        held_dec,
    output xt_pkg::xt_addr_t       held_pc,
    output logic                   seq_start,
    output logic                   busy
);
    import xt_pkg::*;

    localparam int STEP_W = $clog2(MAX_STEPS);

    logic [STEP_W-1:0] cnt;
    logic              last;

    assign seq_start = (state == IDLE) && (dec.kind == MACRO);
    assign busy      = (state == BUSY);
    assign step      = xt_step_t'(cnt);

    // Final micro-op of the held macro
    assign last = (cnt == STEP_W'(MACRO_LEN[held_dec.macro] - 3'd1));

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            state    <= IDLE;
            cnt      <= '0;
            held_dec <= '0;
            held_pc  <= '0;
        end else if (flush) begin
            state    <= IDLE;
            cnt      <= '0;
            held_dec <= '0;
            held_pc  <= '0;
        end else if (!stall) begin
            case (state)
                IDLE: begin
                    // Step 0 goes out this cycle from the live decode
                    if (seq_start) begin
                        state    <= BUSY;
                        cnt      <= STEP_W'(1);
                        held_dec <= dec;
                        held_pc  <= pc;
                    end
                end
                BUSY: begin
                    if (last) begin
                        state <= IDLE;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                    cnt   <= '0;
                end
            endcase
        end
    end

    a_step_in_range: assert property (@(posedge iw_clk) disable iff (iw_rst)
        state == BUSY |-> step < MACRO_LEN[held_dec.macro]);

    a_step_frozen: assert property (@(posedge iw_clk) disable iff (iw_rst)
        stall && !flush |=> $stable(step) && $stable(state));

endmodule

`default_nettype wire

/* verilog/xt_decode.sv */
`default_nettype none

module xt_decode (
    input  wire xt_pkg::xt_word_t instr,
    output xt_pkg::xt_dec_t       dec
);
    import xt_pkg::*;

    logic [3:0] opclass;
    logic [3:0] subop;

    assign opclass = instr[23:20];
    assign subop   = instr[19:16];

    always_comb begin
        dec.kind    = UNDEF;
        dec.macro   = JSR;
        dec.opc     = instr[23:16];
        dec.payload = instr[15:0];

        case (opclass)
            4'h0, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'hF: begin
                dec.kind = PASS;
            end
            OPCLASS_PRIV: begin
                if (subop == SUBOP_SETSSP) begin
                    dec.kind = REWRITE_SSP;
                end else begin
                    dec.kind = PASS;
                end
            end
            OPCLASS_CTRL: begin
                case (subop)
                    SUBOP_BTP: begin
                        dec.kind = TO_NOP;
                    end
                    SUBOP_JCCUI, SUBOP_BCCSR, SUBOP_BCCSO, SUBOP_BALSO: begin
                        dec.kind = PASS;
                    end
                    SUBOP_JSRUI: begin
                        dec.kind  = MACRO;
                        dec.macro = JSR;
                    end
                    SUBOP_BSRSR: begin
                        dec.kind  = MACRO;
                        dec.macro = BSR_REG;
                    end
                    SUBOP_BSRSO: begin
                        dec.kind  = MACRO;
                        dec.macro = BSR_OFF;
                    end
                    SUBOP_RET: begin
                        dec.kind  = MACRO;
                        dec.macro = RET;
                    end
                    default: begin
                        dec.kind = UNDEF;
                    end
                endcase
            end
            OPCLASS_STACK: begin
                if (subop == SUBOP_PUSHUR) begin
                    dec.kind  = MACRO;
                    dec.macro = PUSH;
                end else if (subop == SUBOP_POPUR) begin
                    dec.kind  = MACRO;
                    dec.macro = POP;
                end else begin
                    dec.kind = UNDEF;
                end
            end
            // Opclass 8 and A to E
            default: begin
                dec.kind = UNDEF;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/xt_pkg.sv */
`default_nettype none

package xt_pkg;

    // Widths that carry a meaning
    typedef logic [23:0] xt_word_t;
    typedef logic [23:0] xt_addr_t;
    typedef logic [7:0]  xt_opc_t;
    typedef logic [15:0] xt_payload_t;
    typedef logic [1:0]  xt_sr_t;
    typedef logic [2:0]  xt_step_t;

    // Special registers
    localparam xt_sr_t SR_LR  = 2'd1;
    localparam xt_sr_t SR_SSP = 2'd2;
    localparam xt_sr_t SR_PC  = 2'd3;

    // Opclasses with their own handling
    localparam logic [3:0] OPCLASS_CTRL  = 4'h6;
    localparam logic [3:0] OPCLASS_STACK = 4'h7;
    localparam logic [3:0] OPCLASS_PRIV  = 4'h9;

    // Control flow subops
    localparam logic [3:0] SUBOP_BTP   = 4'h0;
    localparam logic [3:0] SUBOP_JCCUI = 4'h1;
    localparam logic [3:0] SUBOP_BCCSR = 4'h2;
    localparam logic [3:0] SUBOP_BCCSO = 4'h3;
    localparam logic [3:0] SUBOP_BALSO = 4'h4;
    localparam logic [3:0] SUBOP_JSRUI = 4'h5;
    localparam logic [3:0] SUBOP_BSRSR = 4'h6;
    localparam logic [3:0] SUBOP_BSRSO = 4'h7;
    localparam logic [3:0] SUBOP_RET   = 4'h8;

    // Stack and privileged subops
    localparam logic [3:0] SUBOP_PUSHUR = 4'h0;
    localparam logic [3:0] SUBOP_POPUR  = 4'h2;
    localparam logic [3:0] SUBOP_SETSSP = 4'h0;

    // Micro-op opcodes
    localparam xt_opc_t OPC_NOP      = 8'h00;
    localparam xt_opc_t OPC_JCCUI    = 8'h61;
    localparam xt_opc_t OPC_BCCSR    = 8'h62;
    localparam xt_opc_t OPC_BALSO    = 8'h64;
    localparam xt_opc_t OPC_SRADDSI  = 8'hE0;
    localparam xt_opc_t OPC_SRSUBSI  = 8'hE1;
    localparam xt_opc_t OPC_SRLDSO   = 8'hE2;
    localparam xt_opc_t OPC_SRSTSO   = 8'hE3;
    localparam xt_opc_t OPC_SRMOVUR  = 8'hE4;
    localparam xt_opc_t OPC_SRJCCSO  = 8'hE5;
    localparam xt_opc_t OPC_SRMOVAUR = 8'hE6;
    localparam xt_opc_t OPC_CINCI    = 8'hE7;
    localparam xt_opc_t OPC_LDCSO    = 8'hE8;
    localparam xt_opc_t OPC_STCSO    = 8'hE9;

    typedef enum logic [2:0] {
        PASS,
        TO_NOP,
        REWRITE_SSP,
        MACRO,
        UNDEF
    } xt_kind_e;

    typedef enum logic [2:0] {
        JSR,
        BSR_REG,
        BSR_OFF,
        RET,
        PUSH,
        POP
    } xt_macro_e;

    typedef enum logic {
        IDLE,
        BUSY
    } xt_state_e;

    // Opcode rides along so pass-through words can be rebuilt downstream
    typedef struct packed {
        xt_kind_e    kind;
        xt_macro_e   macro;
        xt_opc_t     opc;
        xt_payload_t payload;
    } xt_dec_t;

    // Micro-ops per macro, indexed by xt_macro_e
    localparam xt_step_t MACRO_LEN [6] = '{
        3'd4,
        3'd4,
        3'd4,
        3'd3,
        3'd6,
        3'd6
    };

endpackage

`default_nettype wire
